//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;      // data word or instruction
    typedef logic [7:0]  byte_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int NUM_LANES = 4;     // signed 8-bit lanes per word
    typedef logic [NUM_LANES-1:0] lane_flags_t;   // one positive flag per lane

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_VADD,
        ALU_VSUB,
        ALU_VMAX
    } alu_op_e;

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_LOADING,
        LD_RUNNING
    } load_state_e;

    localparam logic [6:0] OPC_REG = 7'b0110011;   // register-register
    localparam logic [6:0] OPC_IMM = 7'b0010011;   // register-immediate
    localparam logic [6:0] OPC_VEC = 7'b1010111;   // packed lanes

    localparam logic [2:0] F3_ADD  = 3'b000;       // add and sub
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_VADD = 3'b000;
    localparam logic [2:0] F3_VSUB = 3'b001;
    localparam logic [2:0] F3_VMAX = 3'b010;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    localparam byte_t START_BYTE = 8'hFE;         // opens a program
    localparam byte_t END_BYTE   = 8'hFF;         // closes it on a word boundary

endpackage

`default_nettype wire

//--- source/program_loader.sv
`timescale 1ns/100ps
`default_nettype none

module program_loader import cpu_pkg::*; #(
    parameter int IMEM_DEPTH = 64,
    localparam int AW = $clog2(IMEM_DEPTH),
    localparam int LW = $clog2(IMEM_DEPTH + 1)
) (
    input  wire            clk_i,
    input  wire            reset,
    input  wire            load_req_i,
    input  wire byte_t     load_byte_i,
    input  wire            run_done_i,
    output logic           load_ack_o,
    output logic           imem_we_o,
    output logic [AW-1:0]  imem_waddr_o,
    output word_t          imem_wdata_o,
    output logic [LW-1:0]  prog_len_o,
    output logic           go_o,
    output logic           run_start_o
);

    load_state_e   state;
    word_t         shift_q;     // bytes of the word being assembled
    word_t         next_word;
    logic [1:0]    byte_cnt;
    logic [LW-1:0] word_cnt;
    logic          take;        // byte accepted this cycle

    // no new byte while a program runs
    assign take      = load_req_i && !load_ack_o && state != LD_RUNNING;
    assign next_word = {load_byte_i, shift_q[31:8]};   // little-endian fill

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            state       <= LD_IDLE;
            load_ack_o  <= 1'b0;
            byte_cnt    <= '0;
            word_cnt    <= '0;
            prog_len_o  <= '0;
            imem_we_o   <= 1'b0;
            go_o        <= 1'b0;
            run_start_o <= 1'b0;
        end else begin
            imem_we_o   <= 1'b0;
            go_o        <= 1'b0;
            run_start_o <= 1'b0;
            if (take) begin
                load_ack_o <= 1'b1;
            end else if (!load_req_i) begin
                load_ack_o <= 1'b0;   // four-phase return to zero
            end
            case (state)
                LD_IDLE: begin
                    if (take && load_byte_i == START_BYTE) begin
                        state       <= LD_LOADING;
                        byte_cnt    <= '0;
                        word_cnt    <= '0;
                        run_start_o <= 1'b1;
                    end
                end
                LD_LOADING: begin
                    if (take) begin
                        if (load_byte_i == END_BYTE && byte_cnt == 2'd0 && word_cnt != '0) begin
                            prog_len_o <= word_cnt;
                            go_o       <= 1'b1;
                            state      <= LD_RUNNING;
                        end else begin
                            byte_cnt <= byte_cnt + 2'd1;
                            if (byte_cnt == 2'd3) begin
                                imem_we_o <= 1'b1;   // word complete
                                word_cnt  <= word_cnt + 1'b1;
                            end
                        end
                    end
                end
                LD_RUNNING: begin
                    if (run_done_i) state <= LD_IDLE;
                end
                default: state <= LD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (take && state == LD_LOADING) begin
            shift_q      <= next_word;
            imem_wdata_o <= next_word;
            imem_waddr_o <= word_cnt[AW-1:0];
        end
    end

endmodule

`default_nettype wire

//--- source/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_stage import cpu_pkg::*; #(
    parameter int IMEM_DEPTH = 64,
    localparam int AW = $clog2(IMEM_DEPTH),
    localparam int LW = $clog2(IMEM_DEPTH + 1)
) (
    input  wire            clk_i,
    input  wire            reset,
    input  wire            imem_we_i,
    input  wire [AW-1:0]   imem_waddr_i,
    input  wire word_t     imem_wdata_i,
    input  wire [LW-1:0]   prog_len_i,
    input  wire            go_i,
    output logic           fetch_valid_o,
    output logic           fetch_last_o,
    output word_t          fetch_instr_o
);

    word_t         imem [IMEM_DEPTH];
    logic          running;
    logic [LW-1:0] pc;
    logic [LW-1:0] last_pc;
    logic          at_last;

    assign last_pc = prog_len_i - LW'(1);
    assign at_last = pc == last_pc;

    always_ff @(posedge clk_i) begin
        if (imem_we_i) imem[imem_waddr_i] <= imem_wdata_i;
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            running       <= 1'b0;
            pc            <= '0;
            fetch_valid_o <= 1'b0;
            fetch_last_o  <= 1'b0;
        end else begin
            fetch_valid_o <= running;
            fetch_last_o  <= running && at_last;
            if (go_i) begin
                running <= 1'b1;
                pc      <= '0;
            end else if (running) begin
                pc <= pc + 1'b1;   // one instruction per cycle
                if (at_last) running <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (running) fetch_instr_o <= imem[pc[AW-1:0]];
    end

endmodule

`default_nettype wire

//--- source/register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file import cpu_pkg::*; (
    input  wire              clk_i,
    input  wire              reset,
    input  wire reg_addr_t   rs1_i,
    input  wire reg_addr_t   rs2_i,
    input  wire              wb_en_i,
    input  wire reg_addr_t   wb_addr_i,
    input  wire word_t       wb_data_i,
    input  wire lane_flags_t wb_flags_i,
    input  wire reg_addr_t   reg_sel_i,
    input  wire [1:0]        byte_sel_i,
    output word_t            rs1_data_o,
    output word_t            rs2_data_o,
    output byte_t            value_o,
    output logic             lane_pos_o
);

    word_t       regs  [32];
    lane_flags_t flags [32];
    word_t       sel_word;
    lane_flags_t sel_flags;

    // x0 reads zero and a same-cycle write passes straight through
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) return '0;
        if (wb_en_i && wb_addr_i == addr) return wb_data_i;
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i]  <= '0;
                flags[i] <= '0;
            end
        end else if (wb_en_i && wb_addr_i != '0) begin
            regs[wb_addr_i]  <= wb_data_i;
            flags[wb_addr_i] <= wb_flags_i;
        end
    end

    // readout of one lane
    assign sel_word   = regs[reg_sel_i];
    assign sel_flags  = flags[reg_sel_i];
    assign value_o    = sel_word[8*byte_sel_i +: 8];
    assign lane_pos_o = sel_flags[byte_sel_i];

endmodule

`default_nettype wire

//--- source/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  wire            clk_i,
    input  wire            reset,
    input  wire            fetch_valid_i,
    input  wire            fetch_last_i,
    input  wire word_t     fetch_instr_i,
    input  wire word_t     rs1_data_i,
    input  wire word_t     rs2_data_i,
    output reg_addr_t      rs1_o,
    output reg_addr_t      rs2_o,
    output logic           dec_valid_o,
    output logic           dec_last_o,
    output alu_op_e        dec_op_o,
    output reg_addr_t      dec_rd_o,
    output reg_addr_t      dec_rs1_o,
    output reg_addr_t      dec_rs2_o,
    output word_t          dec_a_o,
    output word_t          dec_b_o,
    output logic           dec_use_imm_o,
    output word_t          dec_imm_o
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    alu_op_e    op;
    word_t      imm;

    assign opcode = fetch_instr_i[6:0];
    assign funct3 = fetch_instr_i[14:12];
    assign funct7 = fetch_instr_i[31:25];
    assign rs1_o  = fetch_instr_i[19:15];
    assign rs2_o  = fetch_instr_i[24:20];
    assign imm    = {{20{fetch_instr_i[31]}}, fetch_instr_i[31:20]};   // I-type

    function automatic alu_op_e scalar_op(input logic [2:0] f3);
        case (f3)
            F3_ADD:  return ALU_ADD;
            F3_XOR:  return ALU_XOR;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return ALU_NOP;
        endcase
    endfunction

    always_comb begin
        op = ALU_NOP;   // unknown codes never write
        case (opcode)
            OPC_REG: begin
                if (funct7 == F7_SUB) op = (funct3 == F3_ADD) ? ALU_SUB : ALU_NOP;
                else if (funct7 == F7_BASE) op = scalar_op(funct3);
            end
            OPC_IMM: op = scalar_op(funct3);
            OPC_VEC: begin
                case (funct3)
                    F3_VADD: op = ALU_VADD;
                    F3_VSUB: op = ALU_VSUB;
                    F3_VMAX: op = ALU_VMAX;
                    default: op = ALU_NOP;
                endcase
            end
            default: op = ALU_NOP;
        endcase
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            dec_valid_o <= 1'b0;
            dec_last_o  <= 1'b0;
        end else begin
            dec_valid_o <= fetch_valid_i;
            dec_last_o  <= fetch_valid_i && fetch_last_i;
        end
    end

    always_ff @(posedge clk_i) begin
        dec_op_o      <= op;
        dec_rd_o      <= fetch_instr_i[11:7];
        dec_rs1_o     <= rs1_o;
        dec_rs2_o     <= rs2_o;
        dec_a_o       <= rs1_data_i;
        dec_b_o       <= rs2_data_i;
        dec_use_imm_o <= opcode == OPC_IMM;
        dec_imm_o     <= imm;
    end

endmodule

`default_nettype wire

//--- source/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  wire            clk_i,
    input  wire            reset,
    input  wire            run_start_i,
    input  wire            dec_valid_i,
    input  wire            dec_last_i,
    input  wire alu_op_e   dec_op_i,
    input  wire reg_addr_t dec_rd_i,
    input  wire reg_addr_t dec_rs1_i,
    input  wire reg_addr_t dec_rs2_i,
    input  wire word_t     dec_a_i,
    input  wire word_t     dec_b_i,
    input  wire            dec_use_imm_i,
    input  wire word_t     dec_imm_i,
    output logic           wb_en_o,
    output reg_addr_t      wb_addr_o,
    output word_t          wb_data_o,
    output lane_flags_t    wb_flags_o,
    output logic           run_done_o
);

    word_t       op_a;
    word_t       op_b;
    word_t       rs2_val;
    word_t       scalar_res;
    word_t       vec_res;
    word_t       result;
    lane_flags_t vec_flags;
    lane_flags_t flags;
    logic        fwd_ok;
    logic        is_vec;
    logic        wb_last;    // last instruction sits in the result register

    // previous instruction still in the result register
    assign fwd_ok  = wb_en_o && wb_addr_o != '0;
    assign op_a    = (fwd_ok && wb_addr_o == dec_rs1_i) ? wb_data_o : dec_a_i;
    assign rs2_val = (fwd_ok && wb_addr_o == dec_rs2_i) ? wb_data_o : dec_b_i;
    assign op_b    = dec_use_imm_i ? dec_imm_i : rs2_val;

    always_comb begin
        case (dec_op_i)
            ALU_ADD: scalar_res = op_a + op_b;
            ALU_SUB: scalar_res = op_a - op_b;
            ALU_AND: scalar_res = op_a & op_b;
            ALU_OR:  scalar_res = op_a | op_b;
            ALU_XOR: scalar_res = op_a ^ op_b;
            default: scalar_res = '0;
        endcase
    end

    always_comb begin : lanes
        byte_t la;
        byte_t lb;
        byte_t lr;
        for (int i = 0; i < NUM_LANES; i++) begin
            la = op_a[8*i +: 8];
            lb = op_b[8*i +: 8];
            case (dec_op_i)
                ALU_VSUB: lr = la - lb;   // wraps inside the lane
                ALU_VMAX: lr = ($signed(la) > $signed(lb)) ? la : lb;
                default:  lr = la + lb;
            endcase
            vec_res[8*i +: 8] = lr;
            vec_flags[i]      = !lr[7] && lr != '0;   // signed > 0
        end
    end

    assign is_vec = dec_op_i inside {ALU_VADD, ALU_VSUB, ALU_VMAX};
    assign result = is_vec ? vec_res : scalar_res;
    assign flags  = is_vec ? vec_flags : '0;   // scalar write clears flags

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            wb_en_o    <= 1'b0;
            wb_last    <= 1'b0;
            run_done_o <= 1'b0;
        end else begin
            wb_en_o <= dec_valid_i && dec_op_i != ALU_NOP;
            wb_last <= dec_valid_i && dec_last_i;
            if (run_start_i) begin
                run_done_o <= 1'b0;
            end else if (wb_last) begin
                run_done_o <= 1'b1;   // held until the next program starts
            end
        end
    end

    always_ff @(posedge clk_i) begin
        wb_addr_o  <= dec_rd_i;
        wb_data_o  <= result;
        wb_flags_o <= flags;
    end

endmodule

`default_nettype wire

//--- source/cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter int IMEM_DEPTH = 64,
    localparam int AW = $clog2(IMEM_DEPTH),
    localparam int LW = $clog2(IMEM_DEPTH + 1)
) (
    input  wire            clk_i,
    input  wire            reset,
    input  wire            load_req_i,
    input  wire byte_t     load_byte_i,
    output wire            load_ack_o,
    input  wire reg_addr_t reg_sel_i,
    input  wire [1:0]      byte_sel_i,
    output wire byte_t     value_o,
    output wire            lane_pos_o,
    output wire            run_done_o
);

    logic          imem_we;
    logic [AW-1:0] imem_waddr;
    word_t         imem_wdata;
    logic [LW-1:0] prog_len;
    logic          go;
    logic          run_start;

    logic          fetch_valid;
    logic          fetch_last;
    word_t         fetch_instr;

    reg_addr_t     rs1;
    reg_addr_t     rs2;
    word_t         rs1_data;
    word_t         rs2_data;

    logic          dec_valid;
    logic          dec_last;
    alu_op_e       dec_op;
    reg_addr_t     dec_rd;
    reg_addr_t     dec_rs1;
    reg_addr_t     dec_rs2;
    word_t         dec_a;
    word_t         dec_b;
    logic          dec_use_imm;
    word_t         dec_imm;

    logic          wb_en;
    reg_addr_t     wb_addr;
    word_t         wb_data;
    lane_flags_t   wb_flags;

    program_loader #(.IMEM_DEPTH(IMEM_DEPTH)) u_program_loader (
        .clk_i        (clk_i),
        .reset        (reset),
        .load_req_i   (load_req_i),
        .load_byte_i  (load_byte_i),
        .run_done_i   (run_done_o),
        .load_ack_o   (load_ack_o),
        .imem_we_o    (imem_we),
        .imem_waddr_o (imem_waddr),
        .imem_wdata_o (imem_wdata),
        .prog_len_o   (prog_len),
        .go_o         (go),
        .run_start_o  (run_start)
    );

    fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch_stage (
        .clk_i         (clk_i),
        .reset         (reset),
        .imem_we_i     (imem_we),
        .imem_waddr_i  (imem_waddr),
        .imem_wdata_i  (imem_wdata),
        .prog_len_i    (prog_len),
        .go_i          (go),
        .fetch_valid_o (fetch_valid),
        .fetch_last_o  (fetch_last),
        .fetch_instr_o (fetch_instr)
    );

    decode_stage u_decode_stage (
        .clk_i         (clk_i),
        .reset         (reset),
        .fetch_valid_i (fetch_valid),
        .fetch_last_i  (fetch_last),
        .fetch_instr_i (fetch_instr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .dec_valid_o   (dec_valid),
        .dec_last_o    (dec_last),
        .dec_op_o      (dec_op),
        .dec_rd_o      (dec_rd),
        .dec_rs1_o     (dec_rs1),
        .dec_rs2_o     (dec_rs2),
        .dec_a_o       (dec_a),
        .dec_b_o       (dec_b),
        .dec_use_imm_o (dec_use_imm),
        .dec_imm_o     (dec_imm)
    );

    register_file u_register_file (
        .clk_i      (clk_i),
        .reset      (reset),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .wb_en_i    (wb_en),
        .wb_addr_i  (wb_addr),
        .wb_data_i  (wb_data),
        .wb_flags_i (wb_flags),
        .reg_sel_i  (reg_sel_i),
        .byte_sel_i (byte_sel_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .value_o    (value_o),
        .lane_pos_o (lane_pos_o)
    );

    execute_stage u_execute_stage (
        .clk_i         (clk_i),
        .reset         (reset),
        .run_start_i   (run_start),
        .dec_valid_i   (dec_valid),
        .dec_last_i    (dec_last),
        .dec_op_i      (dec_op),
        .dec_rd_i      (dec_rd),
        .dec_rs1_i     (dec_rs1),
        .dec_rs2_i     (dec_rs2),
        .dec_a_i       (dec_a),
        .dec_b_i       (dec_b),
        .dec_use_imm_i (dec_use_imm),
        .dec_imm_i     (dec_imm),
        .wb_en_o       (wb_en),
        .wb_addr_o     (wb_addr),
        .wb_data_o     (wb_data),
        .wb_flags_o    (wb_flags),
        .run_done_o    (run_done_o)
    );

endmodule

`default_nettype wire

//--- include/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// in-order architectural state of the CPU
word_t       model_regs  [32];
lane_flags_t model_flags [32];

function automatic void reset_model();
    for (int i = 0; i < 32; i++) begin
        model_regs[i]  = '0;
        model_flags[i] = '0;
    end
endfunction

// applies one instruction the way the ISA defines it
function automatic void model_execute(input word_t instr);
    logic [6:0]  opc;
    logic [2:0]  f3;
    reg_addr_t   rd;
    word_t       a;
    word_t       b;
    word_t       res;
    lane_flags_t fl;
    logic        writes;
    byte_t       la;
    byte_t       lb;
    byte_t       lr;
    opc    = instr[6:0];
    f3     = instr[14:12];
    rd     = instr[11:7];
    a      = model_regs[instr[19:15]];
    b      = (opc == OPC_IMM) ? {{20{instr[31]}}, instr[31:20]} : model_regs[instr[24:20]];
    writes = 1'b1;
    fl     = '0;   // scalar results have no positive lanes
    res    = '0;
    if (opc == OPC_VEC) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            la = a[8*i +: 8];
            lb = b[8*i +: 8];
            case (f3)
                3'b000:  lr = la + lb;
                3'b001:  lr = la - lb;
                3'b010:  lr = ($signed(la) >= $signed(lb)) ? la : lb;
                default: writes = 1'b0;
            endcase
            res[8*i +: 8] = lr;
            fl[i] = $signed(lr) > 0;
        end
    end else begin
        case (f3)
            3'b000:  res = (opc == OPC_REG && instr[31:25] == F7_SUB) ? a - b : a + b;
            3'b100:  res = a ^ b;
            3'b110:  res = a | b;
            3'b111:  res = a & b;
            default: writes = 1'b0;
        endcase
    end
    if (writes && rd != '0) begin
        model_regs[rd]  = res;
        model_flags[rd] = fl;
    end
endfunction

task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
        err_value++;
        $display("** Error: %s got %h expected %h", name, got, exp);
    end
endtask

task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
        err_value++;
        $display("** Error: %s got %h expected %h", name, got, exp);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        err_flag++;
        $display("** Error: %s got %h expected %h", name, got, exp);
    end
endtask

`endif

//--- sim/tb_cpu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_PROGS    = 12;
    localparam int MAX_LEN      = 40;

    logic      clk_i;
    logic      reset;
    logic      load_req_i;
    byte_t     load_byte_i;
    logic      load_ack_o;
    reg_addr_t reg_sel_i;
    logic [1:0] byte_sel_i;
    byte_t     value_o;
    logic      lane_pos_o;
    logic      run_done_o;

    int        err_value;
    int        err_flag;
    int        err_proto;
    int        cycle_cnt;
    int        cycle_limit;
    word_t     prog_mem  [NUM_PROGS][MAX_LEN];
    int        prog_size [NUM_PROGS];
    reg_addr_t last_rd;
    reg_addr_t prev_rd;

    `include "tb_ref_model.svh"

    cpu_top #(.IMEM_DEPTH(64)) u_cpu_top (
        .clk_i       (clk_i),
        .reset       (reset),
        .load_req_i  (load_req_i),
        .load_byte_i (load_byte_i),
        .load_ack_o  (load_ack_o),
        .reg_sel_i   (reg_sel_i),
        .byte_sel_i  (byte_sel_i),
        .value_o     (value_o),
        .lane_pos_o  (lane_pos_o),
        .run_done_o  (run_done_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // half of the sources reuse a recent destination
    function automatic reg_addr_t pick_source();
        int sel;
        sel = $urandom_range(0, 3);
        if (sel == 0) return last_rd;
        if (sel == 1) return prev_rd;
        return reg_addr_t'($urandom_range(0, 7));
    endfunction

    function automatic word_t gen_instr();
        logic [2:0]  f3s [4];
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        reg_addr_t   rd;
        word_t       w;
        f3s = '{3'b000, 3'b100, 3'b110, 3'b111};
        rd  = ($urandom_range(0, 3) == 0) ? reg_addr_t'($urandom_range(0, 31))
                                           : reg_addr_t'($urandom_range(0, 7));
        f3  = f3s[$urandom_range(0, 3)];
        case ($urandom_range(0, 2))
            0: begin
                f7 = (f3 == 3'b000 && $urandom_range(0, 1)) ? F7_SUB : F7_BASE;
                w  = {f7, pick_source(), pick_source(), f3, rd, OPC_REG};
            end
            1: begin
                imm = 12'($urandom);
                if ($urandom_range(0, 3) == 0) imm[11:4] = 8'hff;   // 0xFF byte in the word
                w = {imm, pick_source(), f3, rd, OPC_IMM};
            end
            default: begin
                f3 = 3'($urandom_range(0, 2));
                w  = {7'b0, pick_source(), pick_source(), f3, rd, OPC_VEC};
            end
        endcase
        prev_rd = last_rd;
        last_rd = rd;
        return w;
    endfunction

    // four-phase transfer of one byte
    task automatic send_byte(input byte_t b, input logic while_busy);
        @(negedge clk_i);
        if (load_ack_o) begin
            err_proto++;
            $display("handshake failure: ack high before the request was raised");
        end
        load_byte_i = b;
        load_req_i  = 1'b1;
        @(negedge clk_i);
        while (!load_ack_o) @(negedge clk_i);
        if (while_busy && !run_done_o) begin
            err_proto++;
            $display("back-pressure failure: byte acknowledged while a program was running");
        end
        load_req_i = 1'b0;
        @(negedge clk_i);
        while (load_ack_o) @(negedge clk_i);
    endtask

    task automatic check_registers();
        word_t got;
        for (int r = 0; r < 32; r++) begin
            for (int b = 0; b < 4; b++) begin
                @(negedge clk_i);
                reg_sel_i  = reg_addr_t'(r);
                byte_sel_i = 2'(b);
                @(posedge clk_i);
                got[8*b +: 8] = value_o;
                if (r == 0) check_byte($sformatf("value_o x0 byte %0d", b), value_o, 8'h00);
                check_flag($sformatf("lane_pos_o x%0d lane %0d", r, b), lane_pos_o,
                           model_flags[r][b]);
            end
            if (r != 0) check_word($sformatf("value_o x%0d", r), got, model_regs[r]);
        end
    endtask

    initial begin
        forever begin
            @(posedge clk_i);
            cycle_cnt++;
            if (cycle_cnt > cycle_limit) begin
                $display("timeout: the run did not finish within %0d cycles", cycle_limit);
                $display("Test failures found");
                $finish;
            end
        end
    end

    initial begin : main
        int total_bytes;
        int n;
        reset       = 1'b1;
        load_req_i  = 1'b0;
        load_byte_i = '0;
        reg_sel_i   = '0;
        byte_sel_i  = '0;
        err_value   = 0;
        err_flag    = 0;
        err_proto   = 0;
        cycle_cnt   = 0;
        last_rd     = '0;
        prev_rd     = '0;
        void'($urandom(32'hfc30_12fd));
        total_bytes = 1;   // byte sent while idle
        for (int p = 0; p < NUM_PROGS; p++) begin
            n = $urandom_range(1, MAX_LEN);
            prog_size[p] = n;
            for (int i = 0; i < n; i++) prog_mem[p][i] = gen_instr();
            total_bytes += 4 * n + 2;
        end
        cycle_limit = RESET_CYCLES + 200 * (NUM_PROGS + 1) + 20 * total_bytes;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        reset = 1'b0;
        if (load_ack_o !== 1'b0 || run_done_o !== 1'b0) begin
            err_proto++;
            $display("reset failure: load_ack_o or run_done_o not low after reset");
        end
        send_byte(8'h5a, 1'b0);   // ignored while idle
        for (int p = 0; p < NUM_PROGS; p++) begin
            send_byte(START_BYTE, p != 0);
            if (p != 0) begin
                if (run_done_o) begin
                    err_proto++;
                    $display("run_done_o stayed high after a new start byte");
                end
                check_registers();   // previous results carry over
            end
            for (int i = 0; i < prog_size[p]; i++) begin
                for (int b = 0; b < 4; b++) send_byte(prog_mem[p][i][8*b +: 8], 1'b0);
            end
            send_byte(END_BYTE, 1'b0);
            if (run_done_o) begin
                err_proto++;
                $display("run_done_o rose before program %0d could finish", p);
            end
            for (int i = 0; i < prog_size[p]; i++) model_execute(prog_mem[p][i]);
        end
        while (!run_done_o) @(negedge clk_i);
        check_registers();
        $display("errors: value %0d, flag %0d, handshake %0d", err_value, err_flag, err_proto);
        if (err_value + err_flag + err_proto == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
source/cpu_pkg.sv
source/program_loader.sv
source/fetch_stage.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/cpu_top.sv
sim/tb_cpu.sv

//--- Bender.yml
package:
  name: pipelined_cpu

sources:
  - files:
      - source/cpu_pkg.sv
      - source/program_loader.sv
      - source/fetch_stage.sv
      - source/register_file.sv
      - source/decode_stage.sv
      - source/execute_stage.sv
      - source/cpu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/tb_cpu.sv
